// ==== verilog/fp_pkg.sv ====
/*
 * binary32 field widths, exponent bias and limits
 * working exponent type and canonical quiet NaN
 * rounding mode and special-result enums
 */
`default_nettype none

package fp_pkg;

	parameter int EXP_W   = 8;		// exponent field
	parameter int MAN_W   = 23;		// stored fraction, hidden bit not counted
	parameter int BIAS    = 127;
	parameter int EXP_MAX = 255;	// biased exponent of inf and NaN

	// packed float as it sits in a register
	typedef logic [EXP_W+MAN_W:0] word_t;

	// signed working exponent
	// holds e1+e2-bias for any pair of normal inputs, plus headroom
	typedef logic signed [EXP_W+1:0] exp_t;

	// canonical quiet NaN, positive, top fraction bit only
	parameter word_t QNAN = 32'h7fc0_0000;

	// same codes as the RISC-V rm field
	typedef enum logic [2:0] {
		RND_RNE = 3'd0,		// nearest, ties to even
		RND_RTZ = 3'd1,		// towards zero
		RND_RDN = 3'd2,		// towards -inf
		RND_RUP = 3'd3,		// towards +inf
		RND_RMM = 3'd4		// nearest, ties away from zero
	} rnd_mode_e;

	// what the result is forced to, ahead of the arithmetic
	typedef enum logic [1:0] {
		SPEC_NONE = 2'd0,
		SPEC_NAN  = 2'd1,
		SPEC_INF  = 2'd2,
		SPEC_ZERO = 2'd3
	} special_e;

endpackage

`default_nettype wire

// ==== verilog/fp_unpack.sv ====
/*
 * stage a of the binary32 multiplier
 * field split, operand classes, sign and exponent sum, special kind
 * ends in the stage b registers
 */
`timescale 1ns/1ps
`default_nettype none

module fp_unpack #(
	parameter int TAG_W = 6
) (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               start,
	input  fp_pkg::rnd_mode_e                 rnd,
	input  fp_pkg::word_t                     in_1,
	input  fp_pkg::word_t                     in_2,
	input  wire  [TAG_W-1:0]                  rd,
	output logic                              b_valid,
	output logic                              b_sign,
	output fp_pkg::exp_t                      b_exp,
	output logic [fp_pkg::MAN_W:0]            b_sig_1,
	output logic [fp_pkg::MAN_W:0]            b_sig_2,
	output fp_pkg::special_e                  b_spec,
	output fp_pkg::rnd_mode_e                 b_rnd,
	output logic                              b_exc,
	output logic [TAG_W-1:0]                  b_rd
);

	localparam logic [fp_pkg::EXP_W-1:0] E_MAX = fp_pkg::EXP_MAX[fp_pkg::EXP_W-1:0];

	fp_pkg::word_t               op [2];
	logic [fp_pkg::EXP_W-1:0]    exp_f [2];
	logic [fp_pkg::MAN_W-1:0]    frac_f [2];
	logic [1:0]                  sign_f, is_zero, is_inf, is_nan, is_snan;
	fp_pkg::special_e            spec;
	fp_pkg::exp_t                exp_sum;

	assign op[0] = in_1;
	assign op[1] = in_2;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			sign_f[i]  = op[i][fp_pkg::EXP_W+fp_pkg::MAN_W];
			exp_f[i]   = op[i][fp_pkg::MAN_W +: fp_pkg::EXP_W];
			frac_f[i]  = op[i][fp_pkg::MAN_W-1:0];
			is_zero[i] = exp_f[i] == '0;	// subnormals flush here
			is_inf[i]  = exp_f[i] == E_MAX && frac_f[i] == '0;
			is_nan[i]  = exp_f[i] == E_MAX && frac_f[i] != '0;
			is_snan[i] = is_nan[i] && !frac_f[i][fp_pkg::MAN_W-1];	// quiet bit clear
		end
	end

	// inf*0 is invalid, gives NaN as well
	always_comb begin
		if (|is_nan || (is_inf[0] && is_zero[1]) || (is_inf[1] && is_zero[0]))
			spec = fp_pkg::SPEC_NAN;
		else if (|is_inf)
			spec = fp_pkg::SPEC_INF;
		else if (|is_zero)
			spec = fp_pkg::SPEC_ZERO;
		else
			spec = fp_pkg::SPEC_NONE;
	end

	// (e1-bias)+(e2-bias)+bias
	assign exp_sum = fp_pkg::exp_t'({2'b00, exp_f[0]}) + fp_pkg::exp_t'({2'b00, exp_f[1]})
		- fp_pkg::exp_t'(fp_pkg::BIAS);

	always_ff @(posedge clk) begin
		if (reset)
			b_valid <= 1'b0;
		else
			b_valid <= start;
	end

	always_ff @(posedge clk) begin
		b_sign  <= sign_f[0] ^ sign_f[1];
		b_exp   <= exp_sum;
		b_sig_1 <= {!is_zero[0], frac_f[0]};	// hidden bit
		b_sig_2 <= {!is_zero[1], frac_f[1]};
		b_spec  <= spec;
		b_rnd   <= rnd;
		b_exc   <= start && (|is_snan);	// invalid op, only for a real issue
		b_rd    <= rd;
	end

endmodule

`default_nettype wire

// ==== verilog/fp_mant_mul.sv ====
/*
 * stage b of the binary32 multiplier
 * 24x24 unsigned significand product, registered as stage c
 * along with the carried sign, exponent, kind, flag, mode and tag
 */
`timescale 1ns/1ps
`default_nettype none

module fp_mant_mul #(
	parameter int TAG_W = 6
) (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               b_valid,
	input  wire                               b_sign,
	input  fp_pkg::exp_t                      b_exp,
	input  wire  [fp_pkg::MAN_W:0]            b_sig_1,
	input  wire  [fp_pkg::MAN_W:0]            b_sig_2,
	input  fp_pkg::special_e                  b_spec,
	input  fp_pkg::rnd_mode_e                 b_rnd,
	input  wire                               b_exc,
	input  wire  [TAG_W-1:0]                  b_rd,
	output logic                              c_valid,
	output logic                              c_sign,
	output fp_pkg::exp_t                      c_exp,
	output logic [2*fp_pkg::MAN_W+1:0]        c_prod,
	output fp_pkg::special_e                  c_spec,
	output fp_pkg::rnd_mode_e                 c_rnd,
	output logic                              c_exc,
	output logic [TAG_W-1:0]                  c_rd
);

	localparam int SIG_W = fp_pkg::MAN_W + 1;

	logic [2*SIG_W-1:0] prod;

	// behavioural stand-in for a hard multiplier macro
	assign prod = {{SIG_W{1'b0}}, b_sig_1} * {{SIG_W{1'b0}}, b_sig_2};

	always_ff @(posedge clk) begin
		if (reset)
			c_valid <= 1'b0;
		else
			c_valid <= b_valid;
	end

	always_ff @(posedge clk) begin
		c_sign <= b_sign;
		c_exp  <= b_exp;
		c_prod <= prod;
		c_spec <= b_spec;
		c_rnd  <= b_rnd;
		c_exc  <= b_valid && b_exc;	// flag only ever seen with valid
		c_rd   <= b_rd;
	end

endmodule

`default_nettype wire

// ==== verilog/fp_round.sv ====
/*
 * stage c of the binary32 multiplier, combinational
 * one-place normalize, round by mode, overflow and flush-to-zero
 * packs the result word, special kinds first
 */
`timescale 1ns/1ps
`default_nettype none

module fp_round (
	input  wire                               c_sign,
	input  fp_pkg::exp_t                      c_exp,
	input  wire  [2*fp_pkg::MAN_W+1:0]        c_prod,
	input  fp_pkg::special_e                  c_spec,
	input  fp_pkg::rnd_mode_e                 c_rnd,
	output fp_pkg::word_t                     res
);

	localparam int TOP = 2*fp_pkg::MAN_W + 1;	// product msb, set when >= 2.0

	localparam logic [fp_pkg::EXP_W-1:0] E_INF = '1;
	localparam logic [fp_pkg::EXP_W-1:0] E_BIG = {{(fp_pkg::EXP_W-1){1'b1}}, 1'b0};

	logic [TOP:0]               norm;
	logic [fp_pkg::MAN_W-1:0]   frac;
	logic                       guard, sticky, lsb;
	fp_pkg::exp_t               exp_n, exp_r;
	logic                       inc;
	logic [fp_pkg::MAN_W:0]     rounded;
	logic                       carry;
	logic                       ovf, unf;
	logic                       keep_max;

	// product is in [1,4), so at most one place of shift
	always_comb begin
		norm   = c_prod[TOP] ? c_prod : {c_prod[TOP-1:0], 1'b0};
		frac   = norm[TOP-1 -: fp_pkg::MAN_W];
		guard  = norm[TOP-1-fp_pkg::MAN_W];
		sticky = |norm[TOP-2-fp_pkg::MAN_W:0];
		lsb    = frac[0];
		exp_n  = c_exp + fp_pkg::exp_t'(c_prod[TOP]);
	end

	always_comb begin
		case (c_rnd)
		fp_pkg::RND_RNE: inc = guard && (sticky || lsb);	// tie goes to even
		fp_pkg::RND_RTZ: inc = 1'b0;
		fp_pkg::RND_RDN: inc = c_sign && (guard || sticky);
		fp_pkg::RND_RUP: inc = !c_sign && (guard || sticky);
		fp_pkg::RND_RMM: inc = guard;
		default:         inc = 1'b0;
		endcase
	end

	// an all-ones fraction wraps to zero, exponent takes the carry
	assign rounded = {1'b0, frac} + {{fp_pkg::MAN_W{1'b0}}, inc};
	assign carry   = rounded[fp_pkg::MAN_W];
	assign exp_r   = exp_n + fp_pkg::exp_t'(carry);

	assign ovf = exp_r >= fp_pkg::exp_t'(fp_pkg::EXP_MAX);
	assign unf = exp_r <= fp_pkg::exp_t'(0);	// no subnormal results

	// modes that never round away from zero stop at the largest finite
	assign keep_max = c_rnd == fp_pkg::RND_RTZ ||
		(c_rnd == fp_pkg::RND_RDN && !c_sign) ||
		(c_rnd == fp_pkg::RND_RUP && c_sign);

	always_comb begin
		case (c_spec)
		fp_pkg::SPEC_NAN:
			res = fp_pkg::QNAN;
		fp_pkg::SPEC_INF:
			res = {c_sign, E_INF, {fp_pkg::MAN_W{1'b0}}};
		fp_pkg::SPEC_ZERO:
			res = {c_sign, {fp_pkg::EXP_W{1'b0}}, {fp_pkg::MAN_W{1'b0}}};
		default: begin
			if (ovf) begin
				if (keep_max)
					res = {c_sign, E_BIG, {fp_pkg::MAN_W{1'b1}}};
				else
					res = {c_sign, E_INF, {fp_pkg::MAN_W{1'b0}}};
			end else if (unf) begin
				res = {c_sign, {fp_pkg::EXP_W{1'b0}}, {fp_pkg::MAN_W{1'b0}}};	// flush
			end else begin
				res = {c_sign, exp_r[fp_pkg::EXP_W-1:0], rounded[fp_pkg::MAN_W-1:0]};
			end
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/fp_mul_top.sv ====
/*
 * pipelined binary32 multiplier, start to valid in two cycles
 * unpack, significand multiply and round stages, tag carried along
 */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_top #(
	parameter int TAG_W = 6
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  start,
	input  fp_pkg::rnd_mode_e    rnd,
	input  fp_pkg::word_t        in_1,
	input  fp_pkg::word_t        in_2,
	input  wire  [TAG_W-1:0]     rd,
	output logic                 valid,
	output fp_pkg::word_t        res,
	output logic                 exception,
	output logic [TAG_W-1:0]     rd_out
);

	// stage b
	logic                        b_valid, b_sign, b_exc;
	fp_pkg::exp_t                b_exp;
	logic [fp_pkg::MAN_W:0]      b_sig_1, b_sig_2;
	fp_pkg::special_e            b_spec;
	fp_pkg::rnd_mode_e           b_rnd;
	logic [TAG_W-1:0]            b_rd;

	// stage c
	logic                        c_valid, c_sign, c_exc;
	fp_pkg::exp_t                c_exp;
	logic [2*fp_pkg::MAN_W+1:0]  c_prod;
	fp_pkg::special_e            c_spec;
	fp_pkg::rnd_mode_e           c_rnd;
	logic [TAG_W-1:0]            c_rd;

	fp_unpack #(.TAG_W(TAG_W)) u_unpack (
		.clk, .reset, .start, .rnd, .in_1, .in_2, .rd,
		.b_valid, .b_sign, .b_exp, .b_sig_1, .b_sig_2,
		.b_spec, .b_rnd, .b_exc, .b_rd
	);

	fp_mant_mul #(.TAG_W(TAG_W)) u_mant_mul (
		.clk, .reset,
		.b_valid, .b_sign, .b_exp, .b_sig_1, .b_sig_2,
		.b_spec, .b_rnd, .b_exc, .b_rd,
		.c_valid, .c_sign, .c_exp, .c_prod, .c_spec, .c_rnd, .c_exc, .c_rd
	);

	fp_round u_round (
		.c_sign, .c_exp, .c_prod, .c_spec, .c_rnd, .res
	);

	assign valid     = c_valid;
	assign exception = c_exc;
	assign rd_out    = c_rd;

endmodule

`default_nettype wire

// ==== tests/fp_mul_properties.sv ====
/*
 * concurrent checks on the multiplier top level
 * valid timing against start, exception qualified by valid
 */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_properties (
	input wire clk,
	input wire reset,
	input wire start,
	input wire valid,
	input wire exception
);

	// pipeline is cleared by reset
	assert property (@(posedge clk) reset |=> !valid)
		else $error("valid high in the cycle after reset");

	// fixed two-cycle latency
	assert property (@(posedge clk) disable iff (reset) valid == $past(start, 2))
		else $error("valid does not follow start by two cycles");

	assert property (@(posedge clk) disable iff (reset) exception |-> valid)
		else $error("exception raised without valid");

endmodule

bind fp_mul_top fp_mul_properties u_props (
	.clk(clk), .reset(reset), .start(start), .valid(valid), .exception(exception)
);

`default_nettype wire

// ==== tests/fp_mul_tb.sv ====
/*
 * testbench for the pipelined binary32 multiplier
 * case table with expected results, issue loop with random gaps
 * in-order result checker on res, exception and rd_out
 */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_tb;

	localparam int TAG_W    = 6;
	localparam int MAX_WAIT = 20;	// cycles allowed per result

	logic                 clk;
	logic                 reset;
	logic                 start;
	fp_pkg::rnd_mode_e    rnd;
	fp_pkg::word_t        in_1;
	fp_pkg::word_t        in_2;
	logic [TAG_W-1:0]     rd;
	logic                 valid;
	fp_pkg::word_t        res;
	logic                 exception;
	logic [TAG_W-1:0]     rd_out;

	// case table with one entry per index
	string                name_q[$];
	fp_pkg::rnd_mode_e    rnd_q[$];
	fp_pkg::word_t        a_q[$];
	fp_pkg::word_t        b_q[$];
	fp_pkg::word_t        res_q[$];
	logic                 exc_q[$];

	int                   n_run;
	int                   n_pass;
	int                   n_fail;

	fp_mul_top #(.TAG_W(TAG_W)) dut (
		.clk(clk), .reset(reset), .start(start), .rnd(rnd),
		.in_1(in_1), .in_2(in_2), .rd(rd),
		.valid(valid), .res(res), .exception(exception), .rd_out(rd_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic void add_case(input string name, input fp_pkg::rnd_mode_e mode,
		input fp_pkg::word_t a, input fp_pkg::word_t b, input fp_pkg::word_t r, input logic e);
		name_q.push_back(name);
		rnd_q.push_back(mode);
		a_q.push_back(a);
		b_q.push_back(b);
		res_q.push_back(r);
		exc_q.push_back(e);
	endfunction

	task automatic load_table();
		add_case("exact_1p5x2", fp_pkg::RND_RNE, 32'h3fc00000, 32'h40000000, 32'h40400000, 1'b0);
		add_case("exact_neg_rtz", fp_pkg::RND_RTZ, 32'hc0400000, 32'h3f000000, 32'hbfc00000, 1'b0);
		add_case("exact_neg_rup", fp_pkg::RND_RUP, 32'hc0400000, 32'h3f000000, 32'hbfc00000, 1'b0);
		// 1.5*1.5 lands in [2,4) and needs the exponent bump
		add_case("exact_1p5x1p5", fp_pkg::RND_RNE, 32'h3fc00000, 32'h3fc00000, 32'h40100000, 1'b0);
		// (1+2^-23)^2 has the guard clear and sticky set
		add_case("rnd_rne", fp_pkg::RND_RNE, 32'h3f800001, 32'h3f800001, 32'h3f800002, 1'b0);
		add_case("rnd_rtz", fp_pkg::RND_RTZ, 32'h3f800001, 32'h3f800001, 32'h3f800002, 1'b0);
		add_case("rnd_rdn", fp_pkg::RND_RDN, 32'h3f800001, 32'h3f800001, 32'h3f800002, 1'b0);
		add_case("rnd_rup", fp_pkg::RND_RUP, 32'h3f800001, 32'h3f800001, 32'h3f800003, 1'b0);
		add_case("rnd_rmm", fp_pkg::RND_RMM, 32'h3f800001, 32'h3f800001, 32'h3f800002, 1'b0);
		add_case("rnd_neg_rdn", fp_pkg::RND_RDN, 32'hbf800001, 32'h3f800001, 32'hbf800003, 1'b0);
		add_case("rnd_neg_rup", fp_pkg::RND_RUP, 32'hbf800001, 32'h3f800001, 32'hbf800002, 1'b0);
		// significands multiply to 2^47-1 and rounding carries into the exponent
		add_case("rnd_carry", fp_pkg::RND_RNE, 32'h3fa1e58f, 32'h3fca6691, 32'h40000000, 1'b0);
		add_case("rnd_no_carry", fp_pkg::RND_RTZ, 32'h3fa1e58f, 32'h3fca6691, 32'h3fffffff, 1'b0);
		// (1+2^-22)*1.25 is an exact tie with an even lsb
		add_case("tie_rne", fp_pkg::RND_RNE, 32'h3f800002, 32'h3fa00000, 32'h3fa00002, 1'b0);
		add_case("tie_rmm", fp_pkg::RND_RMM, 32'h3f800002, 32'h3fa00000, 32'h3fa00003, 1'b0);
		add_case("qnan_in", fp_pkg::RND_RNE, 32'h7fc00000, 32'h3f800000, 32'h7fc00000, 1'b0);
		add_case("snan_in", fp_pkg::RND_RNE, 32'h7f800001, 32'h3f800000, 32'h7fc00000, 1'b1);
		add_case("inf_x_zero", fp_pkg::RND_RNE, 32'h7f800000, 32'h00000000, 32'h7fc00000, 1'b0);
		add_case("inf_x_neg", fp_pkg::RND_RNE, 32'h7f800000, 32'hc0000000, 32'hff800000, 1'b0);
		add_case("zero_x_neg", fp_pkg::RND_RNE, 32'h00000000, 32'hc0400000, 32'h80000000, 1'b0);
		add_case("ovf_rne", fp_pkg::RND_RNE, 32'h7f7fffff, 32'h40000000, 32'h7f800000, 1'b0);
		add_case("ovf_rup", fp_pkg::RND_RUP, 32'h7f7fffff, 32'h40000000, 32'h7f800000, 1'b0);
		add_case("ovf_rtz", fp_pkg::RND_RTZ, 32'h7f7fffff, 32'h40000000, 32'h7f7fffff, 1'b0);
		add_case("ovf_rdn", fp_pkg::RND_RDN, 32'h7f7fffff, 32'h40000000, 32'h7f7fffff, 1'b0);
		add_case("unf_flush", fp_pkg::RND_RNE, 32'h00800000, 32'h3f000000, 32'h00000000, 1'b0);
		add_case("subnorm_in", fp_pkg::RND_RNE, 32'h00400000, 32'hc0000000, 32'h80000000, 1'b0);
	endtask

	task automatic issue_all();
		int gap;
		for (int i = 0; i < name_q.size(); i++) begin
			@(posedge clk);
			start <= 1'b1;
			rnd   <= rnd_q[i];
			in_1  <= a_q[i];
			in_2  <= b_q[i];
			rd    <= TAG_W'(i);		// tag is the table index
			gap = (i < 5) ? 0 : int'($urandom % 3);	// first ones back to back
			repeat (gap) begin
				@(posedge clk);
				start <= 1'b0;
			end
		end
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic check_result(input int j);
		logic bad;
		bad = 1'b0;
		n_run++;
		if (res !== res_q[j]) begin
			$display("mismatch %s res: expected %h actual %h", name_q[j], res_q[j], res);
			bad = 1'b1;
		end
		if (exception !== exc_q[j]) begin
			$display("mismatch %s exception: expected %b actual %b",
				name_q[j], exc_q[j], exception);
			bad = 1'b1;
		end
		if (rd_out !== TAG_W'(j)) begin
			$display("mismatch %s rd_out: expected %0d actual %0d", name_q[j], j, rd_out);
			bad = 1'b1;
		end
		if (bad) begin
			n_fail++;
		end else begin
			n_pass++;
			$display("ok %s res=%h exception=%b", name_q[j], res, exception);
		end
	endtask

	// outputs settle after the rising edge, so look at the falling edge
	task automatic check_all();
		int waited;
		for (int j = 0; j < name_q.size(); j++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!valid && waited < MAX_WAIT);
			if (!valid) begin
				$display("%s: no valid pulse within %0d cycles, result never arrived",
					name_q[j], MAX_WAIT);
				n_fail++;
				break;
			end
			check_result(j);
		end
	endtask

	initial begin
		void'($urandom(32'h8441));
		reset  = 1'b1;
		start  = 1'b0;
		rnd    = fp_pkg::RND_RNE;
		in_1   = '0;
		in_2   = '0;
		rd     = '0;
		n_run  = 0;
		n_pass = 0;
		n_fail = 0;
		load_table();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		fork
			issue_all();
			check_all();
		join
		repeat (2) @(posedge clk);
		$display("checked %0d of %0d, %0d ok, %0d failed",
			n_run, name_q.size(), n_pass, n_fail);
		if (n_fail == 0 && n_run == name_q.size())
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/fp_pkg.sv
verilog/fp_unpack.sv
verilog/fp_mant_mul.sv
verilog/fp_round.sv
verilog/fp_mul_top.sv
tests/fp_mul_properties.sv
tests/fp_mul_tb.sv

// ==== Makefile ====
TOP = fp_mul_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
